/* vlog.f */
design/vfu_pkg.sv
design/vfu_spill_buffer.sv
design/vfu_ctrl.sv
design/vfu_ipu.sv
design/vfu_writeback.sv
design/vfu_top.sv
dv/vrf_model.sv
dv/vfu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the vector unit testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module vfu_tb -f vlog.f -o vfu_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/vfu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
  exit 1
fi
exit 0

/* dv/vfu_tb.sv */
// Vector integer unit testbench
`timescale 1ns/1ps

module vfu_tb import vfu_pkg::*; ();

  localparam int unsigned N_IPU    = 2;
  localparam int unsigned VLEN     = 256;
  localparam int unsigned WW       = N_IPU * ELEN;
  localparam int unsigned WB       = N_IPU * ELENB;
  localparam int unsigned WPV      = VLEN / WW;
  localparam int unsigned NWORDS   = 32 * WPV;
  localparam int unsigned N_RANDOM = 40;
  localparam int unsigned N_INSTR  = 14 + N_RANDOM;

  logic clk_i, rst_i;
  logic req_valid_i, req_ready_o;
  spatz_id_t req_id_i;
  vfu_op_e req_op_i;
  vew_e req_vsew_i;
  vlen_t req_vl_i;
  vreg_idx_t req_vs1_i, req_vs2_i, req_vd_i, req_rd_i;
  logic [ELEN-1:0] req_rs1_i, req_rs2_i;
  logic req_use_vs1_i, req_use_vs2_i, req_is_scalar_i;
  logic [1:0] vrf_re_o, vrf_rvalid_i;
  vrf_addr_t [1:0] vrf_raddr_o;
  logic [1:0][WW-1:0] vrf_rdata_i;
  logic vrf_we_o, vrf_wvalid_i;
  vrf_addr_t vrf_waddr_o;
  logic [WW-1:0] vrf_wdata_o;
  logic [WB-1:0] vrf_wbe_o;
  logic rsp_valid_o, rsp_ready_i, rsp_wb_o;
  spatz_id_t rsp_id_o;
  vreg_idx_t rsp_rd_o;
  logic [ELEN-1:0] rsp_result_o;

  logic [WW-1:0] shadow [NWORDS];
  vrf_addr_t     exp_addr_q [$];
  logic [WW-1:0] exp_data_q [$];
  logic [WB-1:0] exp_be_q [$];
  vfu_rsp_t      exp_rsp_q [$];
  spatz_id_t     next_id;
  int unsigned   n_rsp, err_word, err_rsp, err_other;

  vfu_top #(.N_IPU(N_IPU), .VLEN(VLEN)) dut0 (.*);

  vrf_model #(.N_IPU(N_IPU), .VLEN(VLEN)) vrf0 (
    .clk_i(clk_i), .rst_i(rst_i), .re_i(vrf_re_o), .raddr_i(vrf_raddr_o),
    .rvalid_o(vrf_rvalid_i), .rdata_o(vrf_rdata_i), .we_i(vrf_we_o),
    .waddr_i(vrf_waddr_o), .wdata_i(vrf_wdata_o), .wbe_i(vrf_wbe_o),
    .wvalid_o(vrf_wvalid_i)
  );

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  always @(negedge clk_i) rsp_ready_i = ($urandom % 4) != 0;

  ////////////////////
  // Reference model
  ////////////////////

  function automatic logic [ELEN-1:0] alu(input vfu_op_e op, input logic [ELEN-1:0] b,
                                          input logic [ELEN-1:0] a);
    case (op)
      VADD:    return b + a;
      VSUB:    return b - a;
      VAND:    return b & a;
      VOR:     return b | a;
      default: return b ^ a;
    endcase
  endfunction

  // Expected writes and response of one instruction
  function automatic void reference(input vfu_req_t r);
    int unsigned   ebits, epw, nwords, nel;
    logic [WW-1:0] v1, v2, res, emask;
    logic [WB-1:0] be;
    logic [ELEN-1:0] a, b;
    vrf_addr_t     da;
    vfu_rsp_t      rsp;
    rsp.id = r.id;
    rsp.rd = r.rd;
    rsp.wb = r.is_scalar;
    rsp.result = alu(r.op, r.rs2, r.rs1);
    if (!r.is_scalar) begin
      ebits  = 8 << r.vsew;
      epw    = WW / ebits;
      nwords = (r.vl + epw - 1) / epw;
      emask  = (WW'(1) << ebits) - 1;
      for (int w = 0; w < nwords; w++) begin
        v1  = shadow[r.vs1 * WPV + w];
        v2  = shadow[r.vs2 * WPV + w];
        nel = (w == nwords - 1) ? r.vl - w * epw : epw;
        res = '0;
        be  = '0;
        for (int e = 0; e < epw; e++) begin
          a = r.use_vs1 ? ELEN'((v1 >> (e * ebits)) & emask) : r.rs1;
          b = r.use_vs2 ? ELEN'((v2 >> (e * ebits)) & emask) : r.rs2;
          res |= (WW'(alu(r.op, b, a)) & emask) << (e * ebits);
          if (e < nel) be |= ((WB'(1) << (ebits / 8)) - 1) << (e * ebits / 8);
        end
        da = vrf_addr_t'(r.vd * WPV + w);
        exp_addr_q.push_back(da);
        exp_data_q.push_back(res);
        exp_be_q.push_back(be);
        for (int k = 0; k < WB; k++) begin
          if (be[k]) shadow[da][8*k +: 8] = res[8*k +: 8];
        end
        rsp.result = res[ELEN-1:0];
      end
    end
    exp_rsp_q.push_back(rsp);
  endfunction

  ////////////////////
  // Compare
  ////////////////////

  task automatic check_word(input vrf_addr_t got_addr, input logic [WW-1:0] got_data,
                            input logic [WB-1:0] got_be, input vrf_addr_t exp_addr,
                            input logic [WW-1:0] exp_data, input logic [WB-1:0] exp_be);
    logic [WW-1:0] m;
    for (int k = 0; k < WB; k++) m[8*k +: 8] = {8{exp_be[k]}};
    if (got_addr !== exp_addr) begin
      err_word++;
      $display("FAILED t=%0t vrf_waddr_o got %h exp %h", $time, got_addr, exp_addr);
    end
    if (got_be !== exp_be) begin
      err_word++;
      $display("FAILED t=%0t vrf_wbe_o got %h exp %h", $time, got_be, exp_be);
    end
    if ((got_data & m) !== (exp_data & m)) begin
      err_word++;
      $display("FAILED t=%0t vrf_wdata_o got %h exp %h", $time, got_data & m, exp_data & m);
    end
  endtask

  task automatic check_rsp(input vfu_rsp_t got, input vfu_rsp_t exp);
    if (got.id !== exp.id) begin
      err_rsp++;
      $display("FAILED t=%0t rsp_id_o got %0d exp %0d", $time, got.id, exp.id);
    end
    if (got.rd !== exp.rd) begin
      err_rsp++;
      $display("FAILED t=%0t rsp_rd_o got %0d exp %0d", $time, got.rd, exp.rd);
    end
    if (got.wb !== exp.wb) begin
      err_rsp++;
      $display("FAILED t=%0t rsp_wb_o got %b exp %b", $time, got.wb, exp.wb);
    end
    if (got.result !== exp.result) begin
      err_rsp++;
      $display("FAILED t=%0t rsp_result_o got %h exp %h", $time, got.result, exp.result);
    end
  endtask

  task automatic check_flag(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      err_other++;
      $display("FAILED t=%0t %s got %b exp %b", $time, name, got, exp);
    end
  endtask

  // Scoreboard, writes and responses in order
  always @(posedge clk_i) begin : scoreboard
    vfu_rsp_t got_rsp;
    if (!rst_i && vrf_we_o && vrf_wvalid_i) begin
      if (exp_addr_q.size() == 0) begin
        err_other++;
        $display("Unexpected VRF write at %0t to word %h", $time, vrf_waddr_o);
      end else begin
        check_word(vrf_waddr_o, vrf_wdata_o, vrf_wbe_o, exp_addr_q.pop_front(),
                   exp_data_q.pop_front(), exp_be_q.pop_front());
      end
    end
    if (!rst_i && rsp_valid_o && rsp_ready_i) begin
      n_rsp++;
      if (exp_rsp_q.size() == 0) begin
        err_other++;
        $display("Unexpected response at %0t with id %0d", $time, rsp_id_o);
      end else begin
        got_rsp.id     = rsp_id_o;
        got_rsp.rd     = rsp_rd_o;
        got_rsp.wb     = rsp_wb_o;
        got_rsp.result = rsp_result_o;
        check_rsp(got_rsp, exp_rsp_q.pop_front());
      end
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  function automatic vfu_req_t make_req(input vfu_op_e op, input vew_e sew, input int vl,
                                        input logic u1, input logic u2, input logic sc);
    vfu_req_t r;
    r.id        = '0;
    r.op        = op;
    r.vsew      = sew;
    r.vl        = vlen_t'(vl);
    r.vs1       = vreg_idx_t'($urandom % 16);
    r.vs2       = vreg_idx_t'($urandom % 16);
    r.vd        = vreg_idx_t'(16 + $urandom % 16);
    r.rs1       = $urandom;
    r.rs2       = $urandom;
    r.rd        = vreg_idx_t'($urandom);
    r.use_vs1   = u1 && !sc;
    r.use_vs2   = u2 && !sc;
    r.is_scalar = sc;
    return r;
  endfunction

  task automatic send(input vfu_req_t req);
    vfu_req_t r;
    r      = req;
    r.id   = next_id;
    next_id = next_id + 1'b1;
    reference(r);
    @(negedge clk_i);
    req_valid_i     = 1'b1;
    req_id_i        = r.id;
    req_op_i        = r.op;
    req_vsew_i      = r.vsew;
    req_vl_i        = r.vl;
    req_vs1_i       = r.vs1;
    req_vs2_i       = r.vs2;
    req_vd_i        = r.vd;
    req_rs1_i       = r.rs1;
    req_rs2_i       = r.rs2;
    req_rd_i        = r.rd;
    req_use_vs1_i   = r.use_vs1;
    req_use_vs2_i   = r.use_vs2;
    req_is_scalar_i = r.is_scalar;
    do @(posedge clk_i); while (!req_ready_o);
  endtask

  initial begin : main
    vew_e sew;
    void'($urandom(41));
    {req_valid_i, req_id_i, req_vl_i, req_vs1_i, req_vs2_i, req_vd_i} = '0;
    {req_rs1_i, req_rs2_i, req_rd_i, req_use_vs1_i, req_use_vs2_i, req_is_scalar_i} = '0;
    req_op_i    = VADD;
    req_vsew_i  = EW_32;
    rsp_ready_i = 1'b0;
    {next_id, n_rsp, err_word, err_rsp, err_other} = '0;
    // Sources live in v0..v15, destinations in v16..v31
    for (int a = 0; a < NWORDS; a++) begin
      for (int k = 0; k < N_IPU; k++) shadow[a][ELEN*k +: ELEN] = $urandom;
      vrf0.mem[a] = shadow[a];
    end
    rst_i = 1'b1;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    // Outputs idle under reset
    check_flag("vrf_re_o", vrf_re_o, 2'b00);
    check_flag("vrf_we_o", {1'b0, vrf_we_o}, 2'b00);
    check_flag("rsp_valid_o", {1'b0, rsp_valid_o}, 2'b00);
    check_flag("req_ready_o", {1'b0, req_ready_o}, 2'b01);
    rst_i = 1'b0;

    send(make_req(VADD, EW_32, 4 * WPV / 2, 1, 1, 0));
    send(make_req(VSUB, EW_32, 4 * WPV / 2, 1, 1, 0));
    for (int s = 0; s < 2; s++) begin
      sew = vew_e'(s);
      send(make_req(VAND, sew, WPV * (WB >> s), 0, 1, 0));
      send(make_req(VOR,  sew, WPV * (WB >> s), 0, 1, 0));
      send(make_req(VXOR, sew, WPV * (WB >> s), 0, 1, 0));
    end
    send(make_req(VADD, EW_32, 1, 0, 0, 1));
    send(make_req(VSUB, EW_32, 1, 0, 0, 1));
    send(make_req(VXOR, EW_32, 1, 0, 0, 1));
    // Tails
    send(make_req(VADD, EW_32, 5, 1, 1, 0));
    send(make_req(VSUB, EW_16, 7, 1, 1, 0));
    send(make_req(VXOR, EW_8, 13, 0, 1, 0));
    for (int i = 0; i < N_RANDOM; i++) begin
      sew = vew_e'($urandom % 3);
      send(make_req(vfu_op_e'($urandom % 5), sew, 1 + $urandom % (WPV * (WB >> sew)),
                    1'($urandom), 1'($urandom), ($urandom % 8) == 0));
    end
    @(negedge clk_i);
    req_valid_i = 1'b0;

    while (n_rsp < N_INSTR) @(posedge clk_i);
    repeat (20) @(posedge clk_i);
    if (exp_addr_q.size() != 0 || exp_rsp_q.size() != 0) begin
      err_other++;
      $display("Expected writes or responses never arrived");
    end
    // Final register file matches the shadow copy
    for (int a = 0; a < NWORDS; a++) begin
      check_word(vrf_addr_t'(a), vrf0.mem[a], '1, vrf_addr_t'(a), shadow[a], '1);
    end
    $display("Error counts: words %0d, responses %0d, other %0d",
             err_word, err_rsp, err_other);
    if (err_word + err_rsp + err_other == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(N_INSTR * 200 * 8);
    $display("Timeout, only %0d of %0d responses arrived", n_rsp, N_INSTR);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

/* dv/vrf_model.sv */
// Vector register file model
`timescale 1ns/1ps

module vrf_model import vfu_pkg::*; #(
  parameter int unsigned N_IPU = 2,
  parameter int unsigned VLEN  = 256
) (
  input  logic                           clk_i,
  input  logic                           rst_i,
  // Read ports, index 0 is vs2 and index 1 is vs1
  input  logic      [1:0]                re_i,
  input  vrf_addr_t [1:0]                raddr_i,
  output logic      [1:0]                rvalid_o,
  output logic      [1:0][N_IPU*ELEN-1:0] rdata_o,
  // Write port
  input  logic                           we_i,
  input  vrf_addr_t                      waddr_i,
  input  logic      [N_IPU*ELEN-1:0]     wdata_i,
  input  logic      [N_IPU*ELENB-1:0]    wbe_i,
  output logic                           wvalid_o
);

  localparam int unsigned NWORDS = 32 * (VLEN / (N_IPU * ELEN));

  logic      [N_IPU*ELEN-1:0] mem [NWORDS];
  logic      [1:0]            rvalid_q;
  vrf_addr_t [1:0]            raddr_q;

  initial wvalid_o = 1'b0;

  // One cycle read latency, data only counts while the address is unchanged
  always @(posedge clk_i) begin
    for (int i = 0; i < 2; i++) begin
      if (rst_i) begin
        rvalid_q[i] <= 1'b0;
      end else begin
        rvalid_q[i] <= re_i[i];
        raddr_q[i]  <= raddr_i[i];
        rdata_o[i]  <= mem[raddr_i[i]];
      end
    end
    if (!rst_i && we_i && wvalid_o) begin
      for (int b = 0; b < N_IPU * ELENB; b++) begin
        if (wbe_i[b]) mem[waddr_i][8*b +: 8] = wdata_i[8*b +: 8];
      end
    end
  end

  for (genvar i = 0; i < 2; i++) begin : gen_rvalid
    assign rvalid_o[i] = rvalid_q[i] && re_i[i] && (raddr_q[i] == raddr_i[i]);
  end

  // Random write back-pressure
  always @(negedge clk_i) begin
    wvalid_o = ($urandom % 4) != 0;
  end

endmodule

/* design/vfu_top.sv */
// Vector integer unit top level
`timescale 1ns/1ps

module vfu_top import vfu_pkg::*; #(
  parameter int unsigned N_IPU = 2,
  parameter int unsigned VLEN  = 256
) (
  input  logic                          clk_i,
  input  logic                          rst_i,
  // Request
  input  logic                          req_valid_i,
  output logic                          req_ready_o,
  input  spatz_id_t                     req_id_i,
  input  vfu_op_e                       req_op_i,
  input  vew_e                          req_vsew_i,
  input  vlen_t                         req_vl_i,
  input  vreg_idx_t                     req_vs1_i,
  input  vreg_idx_t                     req_vs2_i,
  input  vreg_idx_t                     req_vd_i,
  input  logic      [ELEN-1:0]          req_rs1_i,
  input  logic      [ELEN-1:0]          req_rs2_i,
  input  vreg_idx_t                     req_rd_i,
  input  logic                          req_use_vs1_i,
  input  logic                          req_use_vs2_i,
  input  logic                          req_is_scalar_i,
  // VRF read
  output logic      [1:0]               vrf_re_o,
  output vrf_addr_t [1:0]               vrf_raddr_o,
  input  logic      [1:0]               vrf_rvalid_i,
  input  logic      [1:0][N_IPU*ELEN-1:0] vrf_rdata_i,
  // VRF write
  output logic                          vrf_we_o,
  output vrf_addr_t                     vrf_waddr_o,
  output logic      [N_IPU*ELEN-1:0]    vrf_wdata_o,
  output logic      [N_IPU*ELENB-1:0]   vrf_wbe_o,
  input  logic                          vrf_wvalid_i,
  // Response
  output logic                          rsp_valid_o,
  input  logic                          rsp_ready_i,
  output spatz_id_t                     rsp_id_o,
  output vreg_idx_t                     rsp_rd_o,
  output logic                          rsp_wb_o,
  output logic      [ELEN-1:0]          rsp_result_o
);

  localparam int unsigned WORDS_PER_VREG = VLEN / (N_IPU * ELEN);

  if (32 * WORDS_PER_VREG > (1 << $bits(vrf_addr_t))) begin : gen_addr_check
    $error("VRF address too narrow for 32 vector registers");
  end

  vfu_req_t                 req_in, req_q;
  logic                     req_q_valid, req_q_ready;
  logic                     issue_valid;
  vfu_tag_t                 issue_tag;
  logic     [N_IPU-1:0]     lane_ready, lane_valid;
  logic     [N_IPU*ELEN-1:0] lane_result;
  vfu_tag_t [N_IPU-1:0]     lane_tag;
  logic                     result_ready;
  vfu_rsp_t                 wb_rsp, rsp_q;
  logic                     wb_rsp_valid, wb_rsp_ready;

  assign req_in = '{
    id:        req_id_i,
    op:        req_op_i,
    vsew:      req_vsew_i,
    vl:        req_vl_i,
    vs1:       req_vs1_i,
    vs2:       req_vs2_i,
    vd:        req_vd_i,
    rs1:       req_rs1_i,
    rs2:       req_rs2_i,
    rd:        req_rd_i,
    use_vs1:   req_use_vs1_i,
    use_vs2:   req_use_vs2_i,
    is_scalar: req_is_scalar_i
  };

  vfu_spill_buffer #(.T(vfu_req_t)) i_req_queue (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (req_valid_i),
    .ready_o (req_ready_o),
    .data_i  (req_in),
    .valid_o (req_q_valid),
    .ready_i (req_q_ready),
    .data_o  (req_q)
  );

  vfu_ctrl #(.N_IPU(N_IPU), .VLEN(VLEN)) i_ctrl (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .req_valid_i   (req_q_valid),
    .req_i         (req_q),
    .req_ready_o   (req_q_ready),
    .vrf_re_o      (vrf_re_o),
    .vrf_raddr_o   (vrf_raddr_o),
    .vrf_rvalid_i  (vrf_rvalid_i),
    .lane_ready_i  (&lane_ready),
    .issue_valid_o (issue_valid),
    .issue_tag_o   (issue_tag)
  );

  ////////////////////
  // Lanes
  ////////////////////

  // Lanes past 0 sit out the commit of a scalar word
  for (genvar k = 0; k < N_IPU; k++) begin : gen_ipus
    vfu_ipu #(.LANE(k)) i_ipu (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .valid_i        (issue_valid && (!req_q.is_scalar || k == 0)),
      .ready_o        (lane_ready[k]),
      .op_i           (req_q.op),
      .vsew_i         (req_q.vsew),
      .use_vs1_i      (req_q.use_vs1),
      .use_vs2_i      (req_q.use_vs2),
      .vs1_i          (vrf_rdata_i[1][k*ELEN +: ELEN]),
      .vs2_i          (vrf_rdata_i[0][k*ELEN +: ELEN]),
      .rs1_i          (req_q.rs1),
      .rs2_i          (req_q.rs2),
      .tag_i          (issue_tag),
      .result_o       (lane_result[k*ELEN +: ELEN]),
      .result_valid_o (lane_valid[k]),
      .result_ready_i (result_ready && (!lane_tag[0].wb || k == 0)),
      .tag_o          (lane_tag[k])
    );
  end

  vfu_writeback #(.N_IPU(N_IPU)) i_writeback (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .lane_valid_i   (lane_valid),
    .lane_result_i  (lane_result),
    .tag_i          (lane_tag[0]),
    .result_ready_o (result_ready),
    .vrf_we_o       (vrf_we_o),
    .vrf_waddr_o    (vrf_waddr_o),
    .vrf_wdata_o    (vrf_wdata_o),
    .vrf_wbe_o      (vrf_wbe_o),
    .vrf_wvalid_i   (vrf_wvalid_i),
    .rsp_valid_o    (wb_rsp_valid),
    .rsp_o          (wb_rsp),
    .rsp_ready_i    (wb_rsp_ready)
  );

  vfu_spill_buffer #(.T(vfu_rsp_t)) i_rsp_buffer (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (wb_rsp_valid),
    .ready_o (wb_rsp_ready),
    .data_i  (wb_rsp),
    .valid_o (rsp_valid_o),
    .ready_i (rsp_ready_i),
    .data_o  (rsp_q)
  );

  assign rsp_id_o     = rsp_q.id;
  assign rsp_rd_o     = rsp_q.rd;
  assign rsp_wb_o     = rsp_q.wb;
  assign rsp_result_o = rsp_q.result;

endmodule

/* design/vfu_writeback.sv */
// Lane result writeback
`timescale 1ns/1ps

module vfu_writeback import vfu_pkg::*; #(
  parameter int unsigned N_IPU = 2
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  // Lanes
  input  logic [N_IPU-1:0]        lane_valid_i,
  input  logic [N_IPU*ELEN-1:0]   lane_result_i,
  input  vfu_tag_t                tag_i,
  output logic                    result_ready_o,
  // VRF write port
  output logic                    vrf_we_o,
  output vrf_addr_t               vrf_waddr_o,
  output logic [N_IPU*ELEN-1:0]   vrf_wdata_o,
  output logic [N_IPU*ELENB-1:0]  vrf_wbe_o,
  input  logic                    vrf_wvalid_i,
  // Response
  output logic                    rsp_valid_o,
  output vfu_rsp_t                rsp_o,
  input  logic                    rsp_ready_i
);

  logic        words_valid;
  logic        vrf_ok;
  logic [18:0] nbytes;

  // Scalar words only occupy lane 0
  assign words_valid = tag_i.wb ? lane_valid_i[0] : &lane_valid_i;
  assign vrf_ok      = tag_i.wb || vrf_wvalid_i;

  // Last word waits for room in the response buffer before writing
  assign vrf_we_o       = words_valid && !tag_i.wb && (!tag_i.last || rsp_ready_i);
  assign rsp_valid_o    = words_valid && tag_i.last && vrf_ok;
  assign result_ready_o = words_valid && vrf_ok && (!tag_i.last || rsp_ready_i);

  assign vrf_waddr_o = tag_i.vd_addr;
  assign vrf_wdata_o = lane_result_i;

  // Tail mask, bytes past vl stay untouched
  assign nbytes = {3'b000, tag_i.nelem} << tag_i.vsew;

  always_comb begin
    for (int b = 0; b < N_IPU * ELENB; b++) begin
      vrf_wbe_o[b] = nbytes > 19'(b);
    end
  end

  assign rsp_o = '{
    id:     tag_i.id,
    rd:     tag_i.rd,
    wb:     tag_i.wb,
    result: lane_result_i[ELEN-1:0]
  };

  // Lanes hold the word until the VRF takes it
  assert property (@(posedge clk_i) disable iff (rst_i)
    vrf_we_o && !vrf_wvalid_i |=> $stable(vrf_waddr_o) && $stable(vrf_wdata_o))
    else $error("VRF write word changed before acceptance");

endmodule

/* design/vfu_ipu.sv */
// Two-stage SIMD integer lane
`timescale 1ns/1ps

module vfu_ipu import vfu_pkg::*; #(
  parameter int unsigned LANE = 0
) (
  input  logic            clk_i,
  input  logic            rst_i,
  // Issue side
  input  logic            valid_i,
  output logic            ready_o,
  input  vfu_op_e         op_i,
  input  vew_e            vsew_i,
  input  logic            use_vs1_i,
  input  logic            use_vs2_i,
  input  logic [ELEN-1:0] vs1_i,
  input  logic [ELEN-1:0] vs2_i,
  input  logic [ELEN-1:0] rs1_i,
  input  logic [ELEN-1:0] rs2_i,
  input  vfu_tag_t        tag_i,
  // Result side
  output logic [ELEN-1:0] result_o,
  output logic            result_valid_o,
  input  logic            result_ready_i,
  output vfu_tag_t        tag_o
);

  // Scalar instructions only ever reach lane 0
  localparam bit SCALAR_LANE = (LANE == 0);

  logic            is_scalar;
  vew_e            sew_eff;
  logic [ELEN-1:0] opa, opb;
  logic            s1_en, s2_en;

  logic            s1_valid_q;
  vfu_op_e         s1_op_q;
  vew_e            s1_sew_q;
  logic [ELEN-1:0] s1_a_q, s1_b_q;
  vfu_tag_t        s1_tag_q;

  logic            s2_valid_q;
  logic [ELEN-1:0] s2_res_q;
  vfu_tag_t        s2_tag_q;

  logic [ELEN-1:0] sum8, sum16, sum32, arith, alu_res;

  // Stage 1 operand select, scalars run at full width
  assign is_scalar = SCALAR_LANE && tag_i.wb;
  assign sew_eff   = is_scalar ? EW_32 : vsew_i;
  assign opa       = (use_vs1_i && !is_scalar) ? vs1_i : replicate(rs1_i, sew_eff);
  assign opb       = (use_vs2_i && !is_scalar) ? vs2_i : replicate(rs2_i, sew_eff);

  assign s2_en   = s1_valid_q && (!s2_valid_q || result_ready_i);
  assign ready_o = !s1_valid_q || !s2_valid_q || result_ready_i;
  assign s1_en   = valid_i && ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      if (s1_en) s1_valid_q <= 1'b1;
      else if (s2_en) s1_valid_q <= 1'b0;
      if (s2_en) s2_valid_q <= 1'b1;
      else if (result_ready_i) s2_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (s1_en) begin
      s1_op_q  <= op_i;
      s1_sew_q <= sew_eff;
      s1_a_q   <= opa;
      s1_b_q   <= opb;
      s1_tag_q <= tag_i;
    end
    if (s2_en) begin
      s2_res_q <= alu_res;
      s2_tag_q <= s1_tag_q;
    end
  end

  // Stage 2, carries stop at element boundaries
  always_comb begin : alu
    for (int i = 0; i < ELEN / 8; i++) begin
      sum8[8*i +: 8] = (s1_op_q == VSUB) ? s1_b_q[8*i +: 8] - s1_a_q[8*i +: 8]
                                         : s1_b_q[8*i +: 8] + s1_a_q[8*i +: 8];
    end
    for (int i = 0; i < ELEN / 16; i++) begin
      sum16[16*i +: 16] = (s1_op_q == VSUB) ? s1_b_q[16*i +: 16] - s1_a_q[16*i +: 16]
                                            : s1_b_q[16*i +: 16] + s1_a_q[16*i +: 16];
    end
    sum32 = (s1_op_q == VSUB) ? s1_b_q - s1_a_q : s1_b_q + s1_a_q;
    case (s1_sew_q)
      EW_8:    arith = sum8;
      EW_16:   arith = sum16;
      default: arith = sum32;
    endcase
    case (s1_op_q)
      VAND:    alu_res = s1_b_q & s1_a_q;
      VOR:     alu_res = s1_b_q | s1_a_q;
      VXOR:    alu_res = s1_b_q ^ s1_a_q;
      default: alu_res = arith;
    endcase
  end

  assign result_o       = s2_res_q;
  assign result_valid_o = s2_valid_q;
  assign tag_o          = s2_tag_q;

  // Sequencer only issues to a ready lane
  assert property (@(posedge clk_i) disable iff (rst_i) valid_i |-> ready_o)
    else $error("lane %0d got a word while stalled", LANE);

endmodule

/* design/vfu_ctrl.sv */
// Vector instruction sequencer
`timescale 1ns/1ps

module vfu_ctrl import vfu_pkg::*; #(
  parameter int unsigned N_IPU = 2,
  parameter int unsigned VLEN  = 256
) (
  input  logic            clk_i,
  input  logic            rst_i,
  // Head of the request queue
  input  logic            req_valid_i,
  input  vfu_req_t        req_i,
  output logic            req_ready_o,
  // VRF read, index 0 is vs2 and index 1 is vs1
  output logic      [1:0] vrf_re_o,
  output vrf_addr_t [1:0] vrf_raddr_o,
  input  logic      [1:0] vrf_rvalid_i,
  // Lanes
  input  logic            lane_ready_i,
  output logic            issue_valid_o,
  output vfu_tag_t        issue_tag_o
);

  localparam int unsigned WORDS_PER_VREG = VLEN / (N_IPU * ELEN);

  // Elements already issued and word offset inside the register
  vlen_t       cnt_q, cnt_d;
  vrf_addr_t   word_q, word_d;

  vlen_t       epw;
  logic [16:0] cnt_next;
  logic        last_word;
  logic        ops_ready;
  vlen_t       nelem;
  vrf_addr_t   vd_addr;

  assign epw      = elems_per_word(req_i.vsew, N_IPU);
  assign cnt_next = {1'b0, cnt_q} + {1'b0, epw};

  // A scalar instruction is a single word
  assign last_word = req_i.is_scalar || (cnt_next >= {1'b0, req_i.vl});
  assign nelem     = last_word ? req_i.vl - cnt_q : epw;

  ////////////////////
  // Operand request
  ////////////////////

  assign vrf_re_o = {req_i.use_vs1, req_i.use_vs2} & {2{req_valid_i && !req_i.is_scalar}};

  assign vrf_raddr_o[0] = vrf_addr_t'(req_i.vs2 * WORDS_PER_VREG) + word_q;
  assign vrf_raddr_o[1] = vrf_addr_t'(req_i.vs1 * WORDS_PER_VREG) + word_q;
  assign vd_addr        = vrf_addr_t'(req_i.vd * WORDS_PER_VREG) + word_q;

  assign ops_ready = req_i.is_scalar ||
                     ((!req_i.use_vs1 || vrf_rvalid_i[1]) && (!req_i.use_vs2 || vrf_rvalid_i[0]));

  ////////////////////
  // Issue
  ////////////////////

  assign issue_valid_o = req_valid_i && ops_ready && lane_ready_i;

  // Request leaves the queue with its last word
  assign req_ready_o = issue_valid_o && last_word;

  assign issue_tag_o = '{
    id:      req_i.id,
    rd:      req_i.rd,
    vd_addr: vd_addr,
    vsew:    req_i.vsew,
    wb:      req_i.is_scalar,
    last:    last_word,
    nelem:   nelem
  };

  always_comb begin
    cnt_d  = cnt_q;
    word_d = word_q;
    if (issue_valid_o) begin
      if (last_word) begin
        cnt_d  = '0;
        word_d = '0;
      end else begin
        cnt_d  = cnt_next[15:0];
        word_d = word_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q  <= '0;
      word_q <= '0;
    end else begin
      cnt_q  <= cnt_d;
      word_q <= word_d;
    end
  end

  // Counter stays within one word of vl
  assert property (@(posedge clk_i) disable iff (rst_i)
    req_valid_i |-> {1'b0, cnt_q} <= {1'b0, req_i.vl} + {1'b0, epw})
    else $error("element counter ran past vl");

endmodule

/* design/vfu_spill_buffer.sv */
// Two-entry elastic buffer
`timescale 1ns/1ps

module vfu_spill_buffer #(
  parameter type T = logic [31:0]
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  // Entry a takes new data, entry b holds the older word on a stall
  logic a_full_q, b_full_q;
  T     a_data_q, b_data_q;
  logic a_fill, a_drain;
  logic b_fill, b_drain;

  assign a_fill  = valid_i && ready_o;
  assign a_drain = a_full_q && !b_full_q;
  assign b_fill  = a_drain && !ready_i;
  assign b_drain = b_full_q && ready_i;

  assign ready_o = !a_full_q || !b_full_q;
  assign valid_o = a_full_q || b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      a_full_q <= a_fill || (a_full_q && !a_drain);
      b_full_q <= b_fill || (b_full_q && !b_drain);
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) a_data_q <= data_i;
    if (b_fill) b_data_q <= a_data_q;
  end

  // Output word holds while the consumer stalls
  assert property (@(posedge clk_i) disable iff (rst_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o))
    else $error("spill buffer output changed under back-pressure");

endmodule

/* design/vfu_pkg.sv */
// Vector unit shared definitions
package vfu_pkg;

  // Lane geometry
  localparam int unsigned ELEN  = 32;
  localparam int unsigned ELENB = ELEN / 8;

  typedef enum logic [1:0] {
    EW_8  = 2'd0,
    EW_16 = 2'd1,
    EW_32 = 2'd2
  } vew_e;

  typedef enum logic [2:0] {
    VADD = 3'd0,
    VSUB = 3'd1,
    VAND = 3'd2,
    VOR  = 3'd3,
    VXOR = 3'd4
  } vfu_op_e;

  typedef logic [2:0]  spatz_id_t;
  typedef logic [4:0]  vreg_idx_t;
  typedef logic [15:0] vlen_t;
  typedef logic [9:0]  vrf_addr_t;

  typedef struct packed {
    spatz_id_t       id;
    vfu_op_e         op;
    vew_e            vsew;
    vlen_t           vl;
    vreg_idx_t       vs1;
    vreg_idx_t       vs2;
    vreg_idx_t       vd;
    logic [ELEN-1:0] rs1;
    logic [ELEN-1:0] rs2;
    vreg_idx_t       rd;
    logic            use_vs1;
    logic            use_vs2;
    logic            is_scalar;
  } vfu_req_t;

  typedef struct packed {
    spatz_id_t       id;
    vreg_idx_t       rd;
    logic            wb;
    logic [ELEN-1:0] result;
  } vfu_rsp_t;

  // Travels with each word through the lanes
  typedef struct packed {
    spatz_id_t id;
    vreg_idx_t rd;
    vrf_addr_t vd_addr;
    vew_e      vsew;
    logic      wb;
    logic      last;
    vlen_t     nelem;
  } vfu_tag_t;

  function automatic vlen_t elems_per_word(vew_e vsew, int unsigned n_ipu);
    return vlen_t'(n_ipu * (ELENB >> vsew));
  endfunction

  // Scalar copied into every element of one lane
  function automatic logic [ELEN-1:0] replicate(logic [ELEN-1:0] value, vew_e vsew);
    logic [ELEN-1:0] rep;
    case (vsew)
      EW_8:    rep = {4{value[7:0]}};
      EW_16:   rep = {2{value[15:0]}};
      default: rep = value;
    endcase
    return rep;
  endfunction

endpackage
